/* decodeChecker.sv */
// Decode stage result checker with per-test report and pass and fail counters
`default_nettype none

module decodeChecker (
  input  wire                     clk_i,
  input  wire                     rstn_i,
  // Table entry being driven this cycle
  input  wire                     testEn_i,
  input  wire [8*12-1:0]          testName_i,
  input  wire                     instrValid_i,
  input  wire decodePkg::dataT    pc_i,
  input  wire decodePkg::dataT    rs1Val_i,
  input  wire decodePkg::dataT    rs2Val_i,
  input  wire decodePkg::dataT    csrVal_i,
  input  wire [4:0]               expExe_i,
  input  wire [1:0]               expPc_i,
  input  wire [4:0]               expMem_i,
  input  wire [2:0]               expGpr_i,
  input  wire decodePkg::regIdxT  expRs1_i,
  input  wire decodePkg::regIdxT  expRs2_i,
  input  wire decodePkg::regIdxT  expRd_i,
  input  wire decodePkg::csrAddrT expCsr_i,
  input  wire [2:0]               op1Sel_i,
  input  wire [2:0]               op2Sel_i,
  input  wire [2:0]               op3Sel_i,
  input  wire decodePkg::dataT    expImm_i,
  // Observed DUT outputs
  input  wire decodePkg::regIdxT  rs1_i,
  input  wire decodePkg::regIdxT  rs2_i,
  input  wire decodePkg::csrAddrT csrAddr_i,
  input  wire                     valid_i,
  input  wire decodePkg::regIdxT  rd_i,
  input  wire decodePkg::dataT    op1_i,
  input  wire decodePkg::dataT    op2_i,
  input  wire decodePkg::dataT    op3_i,
  input  wire [4:0]               exeCtrl_i,
  input  wire [1:0]               pcCtrl_i,
  input  wire [4:0]               memCtrl_i,
  input  wire [2:0]               gprCtrl_i,
  output int                      testsDone_o,
  output int                      passCount_o,
  output int                      failCount_o
);

  import decodePkg::*;

  // Operand source codes shared with the testbench table
  localparam logic [2:0] SelZero = 3'd0;
  localparam logic [2:0] SelRs1  = 3'd1;
  localparam logic [2:0] SelRs2  = 3'd2;
  localparam logic [2:0] SelPc   = 3'd3;
  localparam logic [2:0] SelImm  = 3'd4;
  localparam logic [2:0] SelCsr  = 3'd5;

  // What the registered outputs must show after the next rising edge
  localparam int KindNone  = 0;
  localparam int KindReset = 1;
  localparam int KindTest  = 2;

  int              pendKind;
  int              errCount;
  logic [8*12-1:0] curName;
  logic            pendValid;
  logic [4:0]      pendExe;
  logic [1:0]      pendPc;
  logic [4:0]      pendMem;
  logic [2:0]      pendGpr;
  regIdxT          pendRd;
  dataT            pendOp1;
  dataT            pendOp2;
  dataT            pendOp3;

  initial begin
    pendKind    = KindNone;
    errCount    = 0;
    testsDone_o = 0;
    passCount_o = 0;
    failCount_o = 0;
  end

  // Operand value from the values driven in this cycle
  function automatic dataT pickOperand(input logic [2:0] sel);
    case (sel)
      SelZero: return '0;
      SelRs1:  return rs1Val_i;
      SelRs2:  return rs2Val_i;
      SelPc:   return pc_i;
      SelImm:  return expImm_i;
      SelCsr:  return csrVal_i;
      // Unknown source code never matches
      default: return 'x;
    endcase
  endfunction

  task automatic compareValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %0s %0s is %h, expected %h",
               $time, curName, what, got, exp);
      errCount = errCount + 1;
    end
  endtask

  task automatic closeTest();
    if (errCount == 0) begin
      passCount_o = passCount_o + 1;
      $display("Test %0s passed", curName);
    end else begin
      failCount_o = failCount_o + 1;
      $display("Test %0s failed with %0d mismatches", curName, errCount);
    end
  endtask

  // Inputs settled since the falling edge
  always @(posedge clk_i) begin
    if (!rstn_i) begin
      pendKind = KindReset;
    end else if (testEn_i) begin
      pendKind = KindTest;
      curName  = testName_i;
      errCount = 0;
      // Register file and CSR file addresses are combinational
      compareValue("rs1_o", rs1_i, expRs1_i);
      compareValue("rs2_o", rs2_i, expRs2_i);
      compareValue("csrAddr_o", csrAddr_i, expCsr_i);
      pendValid = instrValid_i;
      pendExe   = expExe_i;
      pendPc    = expPc_i;
      pendMem   = expMem_i;
      pendGpr   = expGpr_i;
      pendRd    = expRd_i;
      pendOp1   = pickOperand(op1Sel_i);
      pendOp2   = pickOperand(op2Sel_i);
      pendOp3   = pickOperand(op3Sel_i);
    end else begin
      pendKind = KindNone;
    end
  end

  // Registered outputs are stable half a cycle after the edge
  always @(negedge clk_i) begin
    if (pendKind == KindReset) begin
      curName  = "reset";
      errCount = 0;
      compareValue("valid_o", valid_i, 1'b0);
      compareValue("exeCtrl_o", exeCtrl_i, Add);
      compareValue("pcCtrl_o", pcCtrl_i, PcInc);
      compareValue("memCtrl_o", memCtrl_i, MemIdle);
      compareValue("gprCtrl_o", gprCtrl_i, GprIdle);
      closeTest();
    end else if (pendKind == KindTest) begin
      compareValue("valid_o", valid_i, pendValid);
      compareValue("exeCtrl_o", exeCtrl_i, pendExe);
      compareValue("pcCtrl_o", pcCtrl_i, pendPc);
      compareValue("memCtrl_o", memCtrl_i, pendMem);
      compareValue("gprCtrl_o", gprCtrl_i, pendGpr);
      // Payload holds its old value on invalid cycles
      if (pendValid) begin
        compareValue("rd_o", rd_i, pendRd);
        compareValue("op1_o", op1_i, pendOp1);
        compareValue("op2_o", op2_i, pendOp2);
        compareValue("op3_o", op3_i, pendOp3);
      end
      closeTest();
      testsDone_o = testsDone_o + 1;
    end
  end

endmodule

`default_nettype wire

/* decodeCtrl.sv */
// decodeCtrl: opcode classification and ALU, PC, memory and write-back code generation
`default_nettype none

module decodeCtrl (
  input  wire decodePkg::instrT instr_i,
  output decodePkg::opClassE    opClass_o,
  output decodePkg::exeCtrlE    exeCtrl_o,
  output decodePkg::pcCtrlE     pcCtrl_o,
  output decodePkg::memCtrlE    memCtrl_o,
  output decodePkg::gprCtrlE    gprCtrl_o
);

  import decodePkg::*;

  // Instruction fields used by the control logic
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       altBit;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  // funct7 bit 5, selects Sub and Sra
  assign altBit = instr_i[30];

  // Only place where the opcode is compared
  always_comb begin
    case (opcode)
      LoadOp:   opClass_o = OpLoad;
      StoreOp:  opClass_o = OpStore;
      ImmOp:    opClass_o = OpImm;
      RegOp:    opClass_o = OpReg;
      AuipcOp:  opClass_o = OpAuipc;
      LuiOp:    opClass_o = OpLui;
      BranchOp: opClass_o = OpBranch;
      JalrOp:   opClass_o = OpJalr;
      JalOp:    opClass_o = OpJal;
      CsrOp:    opClass_o = OpCsr;
      default:  opClass_o = OpNone;
    endcase
  end

  // ALU code
  always_comb begin
    exeCtrl_o = Add;
    if (opClass_o == OpReg || opClass_o == OpImm) begin
      case (funct3)
        // No subtract-immediate exists
        3'b000:  exeCtrl_o = (opClass_o == OpReg && altBit) ? Sub : Add;
        3'b001:  exeCtrl_o = Sll;
        3'b010:  exeCtrl_o = Slt;
        3'b011:  exeCtrl_o = Sltu;
        3'b100:  exeCtrl_o = Xor;
        3'b101:  exeCtrl_o = altBit ? Sra : Srl;
        3'b110:  exeCtrl_o = Or;
        default: exeCtrl_o = And;
      endcase
    end else if (opClass_o == OpBranch) begin
      case (funct3)
        3'b000:  exeCtrl_o = Eq;
        3'b001:  exeCtrl_o = Ne;
        3'b100:  exeCtrl_o = Slt;
        3'b101:  exeCtrl_o = Ge;
        3'b110:  exeCtrl_o = Sltu;
        3'b111:  exeCtrl_o = Geu;
        // Reserved 010 and 011 fall back to Add
        default: exeCtrl_o = Add;
      endcase
    end
  end

  // Next-PC code, unsupported opcodes just step over
  always_comb begin
    case (opClass_o)
      OpJalr:   pcCtrl_o = PcSet;
      OpJal:    pcCtrl_o = PcAdd;
      OpBranch: pcCtrl_o = PcCond;
      default:  pcCtrl_o = PcInc;
    endcase
  end

  // Memory access code from funct3 size and sign
  always_comb begin
    memCtrl_o = MemIdle;
    if (opClass_o == OpLoad) begin
      case (funct3)
        3'b000:  memCtrl_o = MemRb;
        3'b001:  memCtrl_o = MemRh;
        3'b100:  memCtrl_o = MemRbu;
        3'b101:  memCtrl_o = MemRhu;
        default: memCtrl_o = MemRw;
      endcase
    end else if (opClass_o == OpStore) begin
      case (funct3)
        3'b000:  memCtrl_o = MemWb;
        3'b001:  memCtrl_o = MemWh;
        default: memCtrl_o = MemWw;
      endcase
    end
  end

  // Write-back source
  always_comb begin
    case (opClass_o)
      OpLoad:                          gprCtrl_o = GprMem;
      OpImm, OpReg, OpLui, OpAuipc:    gprCtrl_o = GprAlu;
      OpJal, OpJalr:                   gprCtrl_o = GprPrgmc;
      // CSR value travels on op3
      OpCsr:                           gprCtrl_o = GprOp3;
      default:                         gprCtrl_o = GprIdle;
    endcase
  end

endmodule

`default_nettype wire

/* decodePkg.sv */
// Shared widths, vector types, RV32I opcodes and decode control-code enums
`default_nettype none

package decodePkg;

  // Data path and instruction widths
  localparam int DataWidth    = 32;
  localparam int InstrWidth   = 32;
  // Register file index and CSR address widths
  localparam int RfAddrWidth  = 5;
  localparam int CsrAddrWidth = 12;

  // One data word
  typedef logic [DataWidth-1:0]    dataT;
  // One instruction word
  typedef logic [InstrWidth-1:0]   instrT;
  // GPR index
  typedef logic [RfAddrWidth-1:0]  regIdxT;
  // CSR address
  typedef logic [CsrAddrWidth-1:0] csrAddrT;

  // Major opcodes of the kept RV32I subset
  localparam logic [6:0] LoadOp   = 7'b0000011;
  localparam logic [6:0] ImmOp    = 7'b0010011;
  localparam logic [6:0] AuipcOp  = 7'b0010111;
  localparam logic [6:0] StoreOp  = 7'b0100011;
  localparam logic [6:0] RegOp    = 7'b0110011;
  localparam logic [6:0] LuiOp    = 7'b0110111;
  localparam logic [6:0] BranchOp = 7'b1100011;
  localparam logic [6:0] JalrOp   = 7'b1100111;
  localparam logic [6:0] JalOp    = 7'b1101111;
  localparam logic [6:0] CsrOp    = 7'b1110011;

  // Decoded instruction class, OpNone for anything unsupported
  typedef enum logic [3:0] {
    OpLoad, OpStore, OpImm, OpReg, OpAuipc, OpLui,
    OpBranch, OpJalr, OpJal, OpCsr, OpNone
  } opClassE;

  // ALU operation code
  typedef enum logic [4:0] {
    Add  = 5'd0,
    Sub  = 5'd1,
    Sll  = 5'd2,
    Srl  = 5'd3,
    Sra  = 5'd4,
    Slt  = 5'd5,
    Sltu = 5'd6,
    Xor  = 5'd7,
    Or   = 5'd8,
    And  = 5'd9,
    // Branch-only compares
    Eq   = 5'd10,
    Ne   = 5'd11,
    Ge   = 5'd12,
    Geu  = 5'd13
  } exeCtrlE;

  // Next-PC selection
  typedef enum logic [1:0] {
    PcInc  = 2'd0,
    PcSet  = 2'd1,
    PcAdd  = 2'd2,
    PcCond = 2'd3
  } pcCtrlE;

  // Bit 4 write, bit 3 unsigned, bits 1:0 size
  typedef enum logic [4:0] {
    MemIdle = 5'b00000,
    MemRb   = 5'b00001,
    MemRbu  = 5'b01001,
    MemWb   = 5'b10001,
    MemRh   = 5'b00010,
    MemRhu  = 5'b01010,
    MemWh   = 5'b10010,
    MemRw   = 5'b00011,
    MemWw   = 5'b10011
  } memCtrlE;

  // Write-back source, bit 2 set means a GPR write
  typedef enum logic [2:0] {
    GprIdle  = 3'd0,
    GprMem   = 3'd4,
    GprAlu   = 3'd5,
    GprPrgmc = 3'd6,
    GprOp3   = 3'd7
  } gprCtrlE;

endpackage

`default_nettype wire

/* decodeStage.sv */
// decodeStage: output register for the decode result and its valid flag
`default_nettype none

module decodeStage (
  input  wire                     clk_i,
  input  wire                     rstn_i,
  input  wire                     instrValid_i,
  input  wire decodePkg::regIdxT  rdIdx_i,
  input  wire decodePkg::dataT    op1_i,
  input  wire decodePkg::dataT    op2_i,
  input  wire decodePkg::dataT    op3_i,
  input  wire decodePkg::exeCtrlE exeCtrl_i,
  input  wire decodePkg::pcCtrlE  pcCtrl_i,
  input  wire decodePkg::memCtrlE memCtrl_i,
  input  wire decodePkg::gprCtrlE gprCtrl_i,
  output logic                    valid_o,
  output decodePkg::regIdxT       rd_o,
  output decodePkg::dataT         op1_o,
  output decodePkg::dataT         op2_o,
  output decodePkg::dataT         op3_o,
  output decodePkg::exeCtrlE      exeCtrl_o,
  output decodePkg::pcCtrlE       pcCtrl_o,
  output decodePkg::memCtrlE      memCtrl_o,
  output decodePkg::gprCtrlE      gprCtrl_o
);

  import decodePkg::*;

  // Control codes, idle whenever nothing valid was decoded
  always_ff @(posedge clk_i) begin
    if (!rstn_i || !instrValid_i) begin
      valid_o   <= 1'b0;
      exeCtrl_o <= Add;
      pcCtrl_o  <= PcInc;
      // No memory access and no GPR write leave the stage
      memCtrl_o <= MemIdle;
      gprCtrl_o <= GprIdle;
    end else begin
      valid_o   <= 1'b1;
      exeCtrl_o <= exeCtrl_i;
      pcCtrl_o  <= pcCtrl_i;
      memCtrl_o <= memCtrl_i;
      gprCtrl_o <= gprCtrl_i;
    end
  end

  // Payload, only loaded on a valid instruction
  always_ff @(posedge clk_i) begin
    if (instrValid_i) begin
      rd_o  <= rdIdx_i;
      op1_o <= op1_i;
      op2_o <= op2_i;
      op3_o <= op3_i;
    end
  end

endmodule

`default_nettype wire

/* decodeTop.sv */
// decodeTop: decode stage top level joining control, field, immediate, operand and register blocks
`default_nettype none

module decodeTop (
  input  wire                     clk_i,
  input  wire                     rstn_i,
  input  wire decodePkg::instrT   instr_i,
  input  wire                     instrValid_i,
  input  wire decodePkg::dataT    pc_i,
  input  wire decodePkg::dataT    rs1Val_i,
  input  wire decodePkg::dataT    rs2Val_i,
  input  wire decodePkg::dataT    csrVal_i,
  // To the external register and CSR files, same cycle
  output decodePkg::regIdxT       rs1_o,
  output decodePkg::regIdxT       rs2_o,
  output decodePkg::csrAddrT      csrAddr_o,
  // Registered decode result
  output logic                    valid_o,
  output decodePkg::regIdxT       rd_o,
  output decodePkg::dataT         op1_o,
  output decodePkg::dataT         op2_o,
  output decodePkg::dataT         op3_o,
  output decodePkg::exeCtrlE      exeCtrl_o,
  output decodePkg::pcCtrlE       pcCtrl_o,
  output decodePkg::memCtrlE      memCtrl_o,
  output decodePkg::gprCtrlE      gprCtrl_o
);

  import decodePkg::*;

  // Control path
  opClassE opClass;
  exeCtrlE exeCtrl;
  pcCtrlE  pcCtrl;
  memCtrlE memCtrl;
  gprCtrlE gprCtrl;

  // Data path
  dataT    imm;
  regIdxT  rdIdx;
  dataT    op1;
  dataT    op2;
  dataT    op3;

  decodeCtrl uCtrl (
    .instr_i   (instr_i),
    .opClass_o (opClass),
    .exeCtrl_o (exeCtrl),
    .pcCtrl_o  (pcCtrl),
    .memCtrl_o (memCtrl),
    .gprCtrl_o (gprCtrl)
  );

  regFieldExtract uFields (
    .instr_i   (instr_i),
    .opClass_i (opClass),
    .rs1Idx_o  (rs1_o),
    .rs2Idx_o  (rs2_o),
    .rdIdx_o   (rdIdx),
    .csrAddr_o (csrAddr_o)
  );

  immGen uImm (
    .instr_i   (instr_i),
    .opClass_i (opClass),
    .imm_o     (imm)
  );

  // Register values come back from outside in the same cycle
  operandSelect uOperands (
    .opClass_i (opClass),
    .imm_i     (imm),
    .rs1Val_i  (rs1Val_i),
    .rs2Val_i  (rs2Val_i),
    .csrVal_i  (csrVal_i),
    .pc_i      (pc_i),
    .op1_o     (op1),
    .op2_o     (op2),
    .op3_o     (op3)
  );

  decodeStage uStage (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .instrValid_i (instrValid_i),
    .rdIdx_i      (rdIdx),
    .op1_i        (op1),
    .op2_i        (op2),
    .op3_i        (op3),
    .exeCtrl_i    (exeCtrl),
    .pcCtrl_i     (pcCtrl),
    .memCtrl_i    (memCtrl),
    .gprCtrl_i    (gprCtrl),
    .valid_o      (valid_o),
    .rd_o         (rd_o),
    .op1_o        (op1_o),
    .op2_o        (op2_o),
    .op3_o        (op3_o),
    .exeCtrl_o    (exeCtrl_o),
    .pcCtrl_o     (pcCtrl_o),
    .memCtrl_o    (memCtrl_o),
    .gprCtrl_o    (gprCtrl_o)
  );

endmodule

`default_nettype wire

/* immGen.sv */
// immGen: I, S, B, U and J immediate construction and per-class selection
`default_nettype none

module immGen (
  input  wire decodePkg::instrT   instr_i,
  input  wire decodePkg::opClassE opClass_i,
  output decodePkg::dataT         imm_o
);

  import decodePkg::*;

  // One candidate per format
  dataT iImm;
  dataT shiftImm;
  dataT sImm;
  dataT bImm;
  dataT uImm;
  dataT jImm;
  logic isShift;

  assign iImm     = {{(DataWidth - 12){instr_i[31]}}, instr_i[31:20]};
  // Shift amount field taken as unsigned, funct7 bits included
  assign shiftImm = {{(DataWidth - 12){1'b0}}, instr_i[31:20]};
  assign sImm     = {{(DataWidth - 12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // Branch offset, bit 0 always zero
  assign bImm     = {{(DataWidth - 12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
  // Upper immediate, low 12 bits zero
  assign uImm     = {instr_i[31:12], 12'b0};
  assign jImm     = {{(DataWidth - 20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};

  // funct3 001 is slli, 101 is srli or srai
  assign isShift  = (instr_i[13:12] == 2'b01);

  always_comb begin
    case (opClass_i)
      OpLoad, OpJalr, OpCsr: imm_o = iImm;
      OpImm:                 imm_o = isShift ? shiftImm : iImm;
      OpStore:               imm_o = sImm;
      OpBranch:              imm_o = bImm;
      OpLui, OpAuipc:        imm_o = uImm;
      OpJal:                 imm_o = jImm;
      // R-type and unsupported carry no immediate
      default:               imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* operandSelect.sv */
// operandSelect: op1, op2 and op3 selection from GPR values, PC, immediate and CSR value
`default_nettype none

module operandSelect (
  input  wire decodePkg::opClassE opClass_i,
  input  wire decodePkg::dataT    imm_i,
  input  wire decodePkg::dataT    rs1Val_i,
  input  wire decodePkg::dataT    rs2Val_i,
  input  wire decodePkg::dataT    csrVal_i,
  input  wire decodePkg::dataT    pc_i,
  output decodePkg::dataT         op1_o,
  output decodePkg::dataT         op2_o,
  output decodePkg::dataT         op3_o
);

  import decodePkg::*;

  // op1, first ALU input
  always_comb begin
    case (opClass_i)
      // pc + upper immediate
      OpAuipc:             op1_o = pc_i;
      // Lui and Jal go through the ALU as 0 + imm
      OpLui, OpJal, OpNone: op1_o = '0;
      default:             op1_o = rs1Val_i;
    endcase
  end

  // op2, second ALU input
  always_comb begin
    case (opClass_i)
      // Register compare or register-register op
      OpReg, OpBranch: op2_o = rs2Val_i;
      OpNone:          op2_o = '0;
      // Address offsets and ALU immediates
      default:         op2_o = imm_i;
    endcase
  end

  // op3, side operand for the later stages
  always_comb begin
    case (opClass_i)
      // Store data
      OpStore:  op3_o = rs2Val_i;
      // Branch target offset, the ALU is busy with the compare
      OpBranch: op3_o = imm_i;
      // CSR read value for write-back
      OpCsr:    op3_o = csrVal_i;
      default:  op3_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* regFieldExtract.sv */
// regFieldExtract: rs1, rs2, rd and CSR address extraction with per-class zeroing
`default_nettype none

module regFieldExtract (
  input  wire decodePkg::instrT   instr_i,
  input  wire decodePkg::opClassE opClass_i,
  output decodePkg::regIdxT       rs1Idx_o,
  output decodePkg::regIdxT       rs2Idx_o,
  output decodePkg::regIdxT       rdIdx_o,
  output decodePkg::csrAddrT      csrAddr_o
);

  import decodePkg::*;

  // Unused fields read as zero so the register file sees x0
  always_comb begin
    rs1Idx_o  = instr_i[19:15];
    rs2Idx_o  = '0;
    rdIdx_o   = instr_i[11:7];
    csrAddr_o = '0;

    // Second source only for S, R and B formats
    if (opClass_i == OpStore || opClass_i == OpReg || opClass_i == OpBranch) begin
      rs2Idx_o = instr_i[24:20];
    end

    // U and J formats carry immediate bits where rs1 would be
    if (opClass_i == OpLui || opClass_i == OpAuipc ||
        opClass_i == OpJal || opClass_i == OpNone) begin
      rs1Idx_o = '0;
    end

    // No destination, avoids a stray write
    if (opClass_i == OpStore || opClass_i == OpBranch || opClass_i == OpNone) begin
      rdIdx_o = '0;
    end

    if (opClass_i == OpCsr) begin
      csrAddr_o = instr_i[31:20];
    end
  end

endmodule

`default_nettype wire

/* src.f */
decodePkg.sv
decodeCtrl.sv
regFieldExtract.sv
immGen.sv
operandSelect.sv
decodeStage.sv
decodeTop.sv
decodeChecker.sv
tb_decode.sv

/* tb_decode.sv */
// Testbench top with clock, reset, stimulus table, drive loop and closing summary
`default_nettype none

module tb_decode;

  import decodePkg::*;

  localparam int MaxTests     = 40;
  localparam int ResetTimeout = 20;
  localparam int DoneTimeout  = 20;

  // Operand source codes shared with the checker
  localparam logic [2:0] SelZero = 3'd0;
  localparam logic [2:0] SelRs1  = 3'd1;
  localparam logic [2:0] SelRs2  = 3'd2;
  localparam logic [2:0] SelPc   = 3'd3;
  localparam logic [2:0] SelImm  = 3'd4;
  localparam logic [2:0] SelCsr  = 3'd5;

  // DUT inputs
  logic    clk;
  logic    rstn;
  instrT   instr;
  logic    instrValid;
  dataT    pc;
  dataT    rs1Val;
  dataT    rs2Val;
  dataT    csrVal;

  // DUT outputs
  wire [4:0]  rs1Idx;
  wire [4:0]  rs2Idx;
  wire [11:0] csrAddr;
  wire        validOut;
  wire [4:0]  rdOut;
  wire [31:0] op1;
  wire [31:0] op2;
  wire [31:0] op3;
  wire [4:0]  exeCtrl;
  wire [1:0]  pcCtrl;
  wire [4:0]  memCtrl;
  wire [2:0]  gprCtrl;

  // Expectation of the entry on the bus
  logic            testEn;
  logic [8*12-1:0] testName;
  logic [4:0]      expExe;
  logic [1:0]      expPc;
  logic [4:0]      expMem;
  logic [2:0]      expGpr;
  regIdxT          expRs1;
  regIdxT          expRs2;
  regIdxT          expRd;
  csrAddrT         expCsr;
  logic [2:0]      op1Sel;
  logic [2:0]      op2Sel;
  logic [2:0]      op3Sel;
  dataT            expImm;
  wire [31:0]      testsDone;
  wire [31:0]      passCount;
  wire [31:0]      failCount;

  // Stimulus table with one column per field
  int              numTests;
  instrT           tInstr [MaxTests];
  logic            tValid [MaxTests];
  logic [8*12-1:0] tName  [MaxTests];
  logic [4:0]      tExe   [MaxTests];
  logic [1:0]      tPc    [MaxTests];
  logic [4:0]      tMem   [MaxTests];
  logic [2:0]      tGpr   [MaxTests];
  regIdxT          tRs1   [MaxTests];
  regIdxT          tRs2   [MaxTests];
  regIdxT          tRd    [MaxTests];
  csrAddrT         tCsr   [MaxTests];
  logic [2:0]      tSel1  [MaxTests];
  logic [2:0]      tSel2  [MaxTests];
  logic [2:0]      tSel3  [MaxTests];
  dataT            tImm   [MaxTests];

  decodeTop dut (
    .clk_i(clk), .rstn_i(rstn), .instr_i(instr), .instrValid_i(instrValid),
    .pc_i(pc), .rs1Val_i(rs1Val), .rs2Val_i(rs2Val), .csrVal_i(csrVal),
    .rs1_o(rs1Idx), .rs2_o(rs2Idx), .csrAddr_o(csrAddr), .valid_o(validOut),
    .rd_o(rdOut), .op1_o(op1), .op2_o(op2), .op3_o(op3), .exeCtrl_o(exeCtrl),
    .pcCtrl_o(pcCtrl), .memCtrl_o(memCtrl), .gprCtrl_o(gprCtrl)
  );

  decodeChecker uChecker (
    .clk_i(clk), .rstn_i(rstn), .testEn_i(testEn), .testName_i(testName),
    .instrValid_i(instrValid), .pc_i(pc), .rs1Val_i(rs1Val), .rs2Val_i(rs2Val),
    .csrVal_i(csrVal), .expExe_i(expExe), .expPc_i(expPc), .expMem_i(expMem),
    .expGpr_i(expGpr), .expRs1_i(expRs1), .expRs2_i(expRs2), .expRd_i(expRd),
    .expCsr_i(expCsr), .op1Sel_i(op1Sel), .op2Sel_i(op2Sel), .op3Sel_i(op3Sel),
    .expImm_i(expImm), .rs1_i(rs1Idx), .rs2_i(rs2Idx), .csrAddr_i(csrAddr),
    .valid_i(validOut), .rd_i(rdOut), .op1_i(op1), .op2_i(op2), .op3_i(op3),
    .exeCtrl_i(exeCtrl), .pcCtrl_i(pcCtrl), .memCtrl_i(memCtrl), .gprCtrl_i(gprCtrl),
    .testsDone_o(testsDone), .passCount_o(passCount), .failCount_o(failCount)
  );

  always #10 clk = ~clk;

  task automatic addTest(input logic [8*12-1:0] name, input instrT word, input logic valid,
                         input exeCtrlE exe, input pcCtrlE pcc, input memCtrlE mem,
                         input gprCtrlE gpr, input regIdxT rs1, input regIdxT rs2,
                         input regIdxT rd, input csrAddrT csr, input logic [2:0] sel1,
                         input logic [2:0] sel2, input logic [2:0] sel3, input dataT imm);
    tName[numTests]  = name;
    tInstr[numTests] = word;
    tValid[numTests] = valid;
    tExe[numTests]   = exe;
    tPc[numTests]    = pcc;
    tMem[numTests]   = mem;
    tGpr[numTests]   = gpr;
    tRs1[numTests]   = rs1;
    tRs2[numTests]   = rs2;
    tRd[numTests]    = rd;
    tCsr[numTests]   = csr;
    tSel1[numTests]  = sel1;
    tSel2[numTests]  = sel2;
    tSel3[numTests]  = sel3;
    tImm[numTests]   = imm;
    numTests = numTests + 1;
  endtask

  task automatic buildTable();
    numTests = 0;
    // Register and immediate ALU ops with zero-extended shift immediates
    addTest("add", 32'h002081B3, 1'b1, Add, PcInc, MemIdle, GprAlu,
            5'd1, 5'd2, 5'd3, 12'h000, SelRs1, SelRs2, SelZero, 32'h00000000);
    addTest("sub", 32'h407302B3, 1'b1, Sub, PcInc, MemIdle, GprAlu,
            5'd6, 5'd7, 5'd5, 12'h000, SelRs1, SelRs2, SelZero, 32'h00000000);
    addTest("srl", 32'h00C5D533, 1'b1, Srl, PcInc, MemIdle, GprAlu,
            5'd11, 5'd12, 5'd10, 12'h000, SelRs1, SelRs2, SelZero, 32'h00000000);
    addTest("sra", 32'h40C5D533, 1'b1, Sra, PcInc, MemIdle, GprAlu,
            5'd11, 5'd12, 5'd10, 12'h000, SelRs1, SelRs2, SelZero, 32'h00000000);
    addTest("slt", 32'h003120B3, 1'b1, Slt, PcInc, MemIdle, GprAlu,
            5'd2, 5'd3, 5'd1, 12'h000, SelRs1, SelRs2, SelZero, 32'h00000000);
    addTest("slli", 32'h81F29213, 1'b1, Sll, PcInc, MemIdle, GprAlu,
            5'd5, 5'd0, 5'd4, 12'h000, SelRs1, SelImm, SelZero, 32'h0000081F);
    addTest("srai", 32'hC033D313, 1'b1, Sra, PcInc, MemIdle, GprAlu,
            5'd7, 5'd0, 5'd6, 12'h000, SelRs1, SelImm, SelZero, 32'h00000C03);
    // Loads with a sign-extended I immediate
    addTest("lb", 32'hFFC30283, 1'b1, Add, PcInc, MemRb, GprMem,
            5'd6, 5'd0, 5'd5, 12'h000, SelRs1, SelImm, SelZero, 32'hFFFFFFFC);
    addTest("lh", 32'h00831283, 1'b1, Add, PcInc, MemRh, GprMem,
            5'd6, 5'd0, 5'd5, 12'h000, SelRs1, SelImm, SelZero, 32'h00000008);
    addTest("lw", 32'h7FF32283, 1'b1, Add, PcInc, MemRw, GprMem,
            5'd6, 5'd0, 5'd5, 12'h000, SelRs1, SelImm, SelZero, 32'h000007FF);
    addTest("lbu", 32'h00144383, 1'b1, Add, PcInc, MemRbu, GprMem,
            5'd8, 5'd0, 5'd7, 12'h000, SelRs1, SelImm, SelZero, 32'h00000001);
    addTest("lhu", 32'hFFE45383, 1'b1, Add, PcInc, MemRhu, GprMem,
            5'd8, 5'd0, 5'd7, 12'h000, SelRs1, SelImm, SelZero, 32'hFFFFFFFE);
    // Stores carry rs2 data on op3 and no destination
    addTest("sb", 32'hFE950FA3, 1'b1, Add, PcInc, MemWb, GprIdle,
            5'd10, 5'd9, 5'd0, 12'h000, SelRs1, SelImm, SelRs2, 32'hFFFFFFFF);
    addTest("sh", 32'h02951223, 1'b1, Add, PcInc, MemWh, GprIdle,
            5'd10, 5'd9, 5'd0, 12'h000, SelRs1, SelImm, SelRs2, 32'h00000024);
    addTest("sw", 32'h80B62023, 1'b1, Add, PcInc, MemWw, GprIdle,
            5'd12, 5'd11, 5'd0, 12'h000, SelRs1, SelImm, SelRs2, 32'hFFFFF800);
    // Branches carry the B immediate on op3
    addTest("beq", 32'h00208863, 1'b1, Eq, PcCond, MemIdle, GprIdle,
            5'd1, 5'd2, 5'd0, 12'h000, SelRs1, SelRs2, SelImm, 32'h00000010);
    addTest("bne", 32'hFE209CE3, 1'b1, Ne, PcCond, MemIdle, GprIdle,
            5'd1, 5'd2, 5'd0, 12'h000, SelRs1, SelRs2, SelImm, 32'hFFFFFFF8);
    addTest("blt", 32'h0020C863, 1'b1, Slt, PcCond, MemIdle, GprIdle,
            5'd1, 5'd2, 5'd0, 12'h000, SelRs1, SelRs2, SelImm, 32'h00000010);
    addTest("bge", 32'h0020D863, 1'b1, Ge, PcCond, MemIdle, GprIdle,
            5'd1, 5'd2, 5'd0, 12'h000, SelRs1, SelRs2, SelImm, 32'h00000010);
    addTest("bltu", 32'h0020E863, 1'b1, Sltu, PcCond, MemIdle, GprIdle,
            5'd1, 5'd2, 5'd0, 12'h000, SelRs1, SelRs2, SelImm, 32'h00000010);
    addTest("bgeu", 32'h0041F0E3, 1'b1, Geu, PcCond, MemIdle, GprIdle,
            5'd3, 5'd4, 5'd0, 12'h000, SelRs1, SelRs2, SelImm, 32'h00000800);
    // Reserved funct3 falls back to Add
    addTest("branch010", 32'h0020A863, 1'b1, Add, PcCond, MemIdle, GprIdle,
            5'd1, 5'd2, 5'd0, 12'h000, SelRs1, SelRs2, SelImm, 32'h00000010);
    // Jumps and upper immediates
    addTest("jal", 32'hFFDFF0EF, 1'b1, Add, PcAdd, MemIdle, GprPrgmc,
            5'd0, 5'd0, 5'd1, 12'h000, SelZero, SelImm, SelZero, 32'hFFFFFFFC);
    addTest("jalr", 32'h00C280E7, 1'b1, Add, PcSet, MemIdle, GprPrgmc,
            5'd5, 5'd0, 5'd1, 12'h000, SelRs1, SelImm, SelZero, 32'h0000000C);
    addTest("lui", 32'h12345137, 1'b1, Add, PcInc, MemIdle, GprAlu,
            5'd0, 5'd0, 5'd2, 12'h000, SelZero, SelImm, SelZero, 32'h12345000);
    addTest("auipc", 32'hFFFFF197, 1'b1, Add, PcInc, MemIdle, GprAlu,
            5'd0, 5'd0, 5'd3, 12'h000, SelPc, SelImm, SelZero, 32'hFFFFF000);
    // CSR read of address B00
    addTest("csrRead", 32'hB000A273, 1'b1, Add, PcInc, MemIdle, GprOp3,
            5'd1, 5'd0, 5'd4, 12'hB00, SelRs1, SelImm, SelCsr, 32'hFFFFFB00);
    addTest("unsupported", 32'hFFFFFFFF, 1'b1, Add, PcInc, MemIdle, GprIdle,
            5'd0, 5'd0, 5'd0, 12'h000, SelZero, SelZero, SelZero, 32'h00000000);
    // Invalid cycles give idle codes whatever the instruction
    addTest("idleAdd", 32'h002081B3, 1'b0, Add, PcInc, MemIdle, GprIdle,
            5'd1, 5'd2, 5'd3, 12'h000, SelZero, SelZero, SelZero, 32'h00000000);
    addTest("idleStore", 32'hFE950FA3, 1'b0, Add, PcInc, MemIdle, GprIdle,
            5'd10, 5'd9, 5'd0, 12'h000, SelZero, SelZero, SelZero, 32'h00000000);
  endtask

  // Put one entry and fresh random register values on the bus
  task automatic applyEntry(input int idx);
    instr      = tInstr[idx];
    instrValid = tValid[idx];
    testName   = tName[idx];
    pc         = $urandom;
    rs1Val     = $urandom;
    rs2Val     = $urandom;
    csrVal     = $urandom;
    expExe     = tExe[idx];
    expPc      = tPc[idx];
    expMem     = tMem[idx];
    expGpr     = tGpr[idx];
    expRs1     = tRs1[idx];
    expRs2     = tRs2[idx];
    expRd      = tRd[idx];
    expCsr     = tCsr[idx];
    op1Sel     = tSel1[idx];
    op2Sel     = tSel2[idx];
    op3Sel     = tSel3[idx];
    expImm     = tImm[idx];
    testEn     = 1'b1;
  endtask

  // Reset held for four rising edges
  initial begin
    rstn = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

  initial begin
    int          waitCnt;
    logic        timedOut;
    int unsigned seed;
    int unsigned seedDummy;
    clk        = 1'b0;
    // Valid instruction during reset that must not reach the outputs
    instr      = 32'h002081B3;
    instrValid = 1'b1;
    pc         = '0;
    rs1Val     = '0;
    rs2Val     = '0;
    csrVal     = '0;
    testEn     = 1'b0;
    testName   = '0;
    expExe     = '0;
    expPc      = '0;
    expMem     = '0;
    expGpr     = '0;
    expRs1     = '0;
    expRs2     = '0;
    expRd      = '0;
    expCsr     = '0;
    op1Sel     = SelZero;
    op2Sel     = SelZero;
    op3Sel     = SelZero;
    expImm     = '0;
    timedOut   = 1'b0;
    seed       = 32'h7799;
    seedDummy  = $urandom(seed);
    buildTable();

    // rstn changes on the falling edge, so look at it on the rising one
    waitCnt = 0;
    while (rstn !== 1'b1 && waitCnt < ResetTimeout) begin
      @(posedge clk);
      waitCnt = waitCnt + 1;
    end
    if (rstn !== 1'b1) begin
      timedOut = 1'b1;
      $display("Timeout: reset was not released within %0d cycles", ResetTimeout);
    end else begin
      // One instruction per cycle back to back
      for (int i = 0; i < numTests; i++) begin
        @(negedge clk);
        applyEntry(i);
      end
      @(negedge clk);
      testEn     = 1'b0;
      instrValid = 1'b0;
      // The checker counts on the falling edge
      waitCnt = 0;
      while (testsDone < numTests && waitCnt < DoneTimeout) begin
        @(posedge clk);
        waitCnt = waitCnt + 1;
      end
      if (testsDone < numTests) begin
        timedOut = 1'b1;
        $display("Timeout: only %0d of %0d table tests finished", testsDone, numTests);
      end
    end

    $display("Summary: %0d tests passed, %0d tests failed", passCount, failCount);
    if (!timedOut && failCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
